// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_riscv
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+.
riscv_pkg.sv
decode_if.sv
inst_decoder.sv
reg_file.sv
alu.sv
pc_unit.sv
riscv_core.sv
tb_riscv.sv

// ==== alu.sv ====
// Combinational; shift amounts use only the low 6 bits of the second operand
`timescale 1ns/1ps

module alu (
    decode_if.datapath                 dec,
    input  logic [riscv_pkg::xlen-1:0] rdata1,
    input  logic [riscv_pkg::xlen-1:0] rdata2,
    output logic [riscv_pkg::xlen-1:0] result,
    output logic                       zero
);

    logic [riscv_pkg::xlen-1:0] opnd_b;
    logic [5:0]                 shamt;

    assign opnd_b = dec.use_imm ? dec.imm : rdata2;
    assign shamt  = opnd_b[5:0];

    always_comb begin
        case (dec.alu_op)
            riscv_pkg::alu_add: result = rdata1 + opnd_b;
            riscv_pkg::alu_sub: result = rdata1 - opnd_b;
            riscv_pkg::alu_sll: result = rdata1 << shamt;
            // Signed compare
            riscv_pkg::alu_slt: result = {63'b0, $signed(rdata1) < $signed(opnd_b)};
            riscv_pkg::alu_xor: result = rdata1 ^ opnd_b;
            riscv_pkg::alu_srl: result = rdata1 >> shamt;
            riscv_pkg::alu_sra: result = $unsigned($signed(rdata1) >>> shamt);
            riscv_pkg::alu_or:  result = rdata1 | opnd_b;
            riscv_pkg::alu_and: result = rdata1 & opnd_b;
            default:            result = '0;
        endcase
    end

    // Branch condition source
    assign zero = (result == '0);

endmodule

// ==== decode_if.sv ====
// Plain levels for the current instruction only, no handshake; only the decoder drives fields
`timescale 1ns/1ps

interface decode_if;

    logic [riscv_pkg::reg_idx_w-1:0] rs1;
    logic [riscv_pkg::reg_idx_w-1:0] rs2;
    logic [riscv_pkg::reg_idx_w-1:0] rd;
    logic [riscv_pkg::xlen-1:0]      imm;
    riscv_pkg::alu_op_e              alu_op;
    logic                            use_imm;
    // Never set for rd equal to x0
    logic                            reg_write;
    logic                            mem_write;
    riscv_pkg::wb_sel_e              wb_sel;
    logic                            is_branch;
    logic                            branch_ne;
    logic                            is_jal;
    logic                            is_jalr;

    modport decoder (
        output rs1, rs2, rd, imm, alu_op, use_imm, reg_write, mem_write, wb_sel,
        output is_branch, branch_ne, is_jal, is_jalr
    );

    modport datapath (
        input rs1, rs2, rd, imm, alu_op, use_imm, reg_write, mem_write, wb_sel,
        input is_branch, branch_ne, is_jal, is_jalr
    );

endinterface

// ==== inst_decoder.sv ====
// Expects the instruction already byte-swapped; any unsupported encoding decodes as a no-op
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]     instr,
    decode_if.decoder       dec
);

    riscv_pkg::opcode_e opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic               rd_write;

    assign opcode = riscv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Register indices sit at fixed positions in every format
    assign dec.rs1 = instr[19:15];
    assign dec.rs2 = instr[24:20];
    assign dec.rd  = instr[11:7];

    // x0 writes are dropped here so the register file sees no write
    assign dec.reg_write = rd_write && (instr[11:7] != '0);

    always_comb begin
        dec.imm       = '0;
        dec.alu_op    = riscv_pkg::alu_add;
        dec.use_imm   = 1'b0;
        dec.mem_write = 1'b0;
        dec.wb_sel    = riscv_pkg::wb_alu;
        dec.is_branch = 1'b0;
        dec.branch_ne = 1'b0;
        dec.is_jal    = 1'b0;
        dec.is_jalr   = 1'b0;
        rd_write      = 1'b0;

        case (opcode)
            riscv_pkg::op_jal: begin
                dec.imm    = {{43{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
                dec.is_jal = 1'b1;
                dec.wb_sel = riscv_pkg::wb_link;
                rd_write   = 1'b1;
            end
            riscv_pkg::op_jalr: begin
                dec.imm = {{52{instr[31]}}, instr[31:20]};
                if (funct3 == 3'b000) begin
                    dec.is_jalr = 1'b1;
                    dec.wb_sel  = riscv_pkg::wb_link;
                    rd_write    = 1'b1;
                end
            end
            riscv_pkg::op_branch: begin
                dec.imm    = {{51{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
                // Compare by subtraction, taken on the zero flag
                dec.alu_op = riscv_pkg::alu_sub;
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    dec.is_branch = 1'b1;
                    dec.branch_ne = funct3[0];
                end
            end
            riscv_pkg::op_load: begin
                dec.imm     = {{52{instr[31]}}, instr[31:20]};
                dec.use_imm = 1'b1;
                if (funct3 == 3'b011) begin
                    dec.wb_sel = riscv_pkg::wb_mem;
                    rd_write   = 1'b1;
                end
            end
            riscv_pkg::op_store: begin
                dec.imm     = {{52{instr[31]}}, instr[31:25], instr[11:7]};
                dec.use_imm = 1'b1;
                dec.mem_write = (funct3 == 3'b011);
            end
            riscv_pkg::op_imm: begin
                dec.imm     = {{52{instr[31]}}, instr[31:20]};
                dec.use_imm = 1'b1;
                // ADDI is the only immediate operation kept
                rd_write    = (funct3 == 3'b000);
            end
            riscv_pkg::op_reg: begin
                // funct7 bit 5 selects SUB and SRA, legal only with funct3 000 and 101
                dec.alu_op = riscv_pkg::alu_op_e'({funct7[5], funct3});
                if (funct7 == 7'b0000000) begin
                    rd_write = (funct3 != 3'b011);
                end else if (funct7 == 7'b0100000) begin
                    rd_write = (funct3 == 3'b000 || funct3 == 3'b101);
                end
            end
            default: begin
                rd_write = 1'b0;
            end
        endcase
    end

endmodule

// ==== pc_unit.sv ====
// Word-addressed PC; targets wrap modulo 2^30 words and address bits 1:0 are dropped
`timescale 1ns/1ps

module pc_unit #(
    parameter logic [riscv_pkg::pc_w-1:0] reset_pc = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    decode_if.datapath                 dec,
    input  logic                       zero,
    input  logic [riscv_pkg::xlen-1:0] rdata1,
    output logic [riscv_pkg::pc_w-1:0] pc,
    output logic [riscv_pkg::xlen-1:0] link
);

    logic [riscv_pkg::pc_w-1:0] pc_seq;
    logic [riscv_pkg::pc_w-1:0] pc_rel;
    logic [riscv_pkg::xlen-1:0] jalr_sum;
    logic                       br_taken;
    logic [riscv_pkg::pc_w-1:0] pc_next;

    assign pc_seq   = pc + 1'b1;
    // Byte offset to word offset
    assign pc_rel   = pc + dec.imm[riscv_pkg::pc_w+1:2];
    assign jalr_sum = rdata1 + dec.imm;
    assign br_taken = dec.is_branch && (zero != dec.branch_ne);

    always_comb begin
        if (br_taken || dec.is_jal) begin
            pc_next = pc_rel;
        end else if (dec.is_jalr) begin
            pc_next = jalr_sum[riscv_pkg::pc_w+1:2];
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // Byte address of the next instruction
    assign link = {{(riscv_pkg::xlen-riscv_pkg::pc_w-2){1'b0}}, pc_seq, 2'b00};

endmodule

// ==== reg_file.sv ====
// Reads are combinational; a write lands on the clock edge and shows up the next cycle
`timescale 1ns/1ps

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    decode_if.datapath                 dec,
    input  logic [riscv_pkg::xlen-1:0] wdata,
    output logic [riscv_pkg::xlen-1:0] rdata1,
    output logic [riscv_pkg::xlen-1:0] rdata2
);

    localparam int num_regs = 2 ** riscv_pkg::reg_idx_w;

    logic [riscv_pkg::xlen-1:0] regs [num_regs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (dec.reg_write) begin
            regs[dec.rd] <= wdata;
        end
    end

    // x0 keeps its reset value since the decoder never writes it
    assign rdata1 = regs[dec.rs1];
    assign rdata2 = regs[dec.rs2];

endmodule

// ==== riscv_core.sv ====
// Single-cycle core; both memories must answer combinationally and store bytes big-endian
`timescale 1ns/1ps

module riscv_core #(
    parameter logic [riscv_pkg::pc_w-1:0] reset_pc = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic [riscv_pkg::pc_w-1:0] mem_addr_I,
    input  logic [31:0]                mem_rdata_I,
    output logic                       mem_wen_D,
    output logic [riscv_pkg::pc_w-1:0] mem_addr_D,
    output logic [riscv_pkg::xlen-1:0] mem_wdata_D,
    input  logic [riscv_pkg::xlen-1:0] mem_rdata_D
);

    logic [31:0]                instr;
    logic [riscv_pkg::xlen-1:0] rdata1;
    logic [riscv_pkg::xlen-1:0] rdata2;
    logic [riscv_pkg::xlen-1:0] alu_result;
    logic                       alu_zero;
    logic [riscv_pkg::xlen-1:0] link;
    logic [riscv_pkg::xlen-1:0] load_data;
    logic [riscv_pkg::xlen-1:0] wb_data;

    decode_if dec_bus ();

    // Memory words arrive big-endian
    assign instr     = riscv_pkg::swap32(mem_rdata_I);
    assign load_data = riscv_pkg::swap64(mem_rdata_D);

    inst_decoder decoder_i (
        .instr (instr),
        .dec   (dec_bus)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .dec    (dec_bus),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu alu_i (
        .dec    (dec_bus),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .result (alu_result),
        .zero   (alu_zero)
    );

    pc_unit #(
        .reset_pc (reset_pc)
    ) pc_unit_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .dec    (dec_bus),
        .zero   (alu_zero),
        .rdata1 (rdata1),
        .pc     (mem_addr_I),
        .link   (link)
    );

    // Write-back source
    always_comb begin
        case (dec_bus.wb_sel)
            riscv_pkg::wb_mem:  wb_data = load_data;
            riscv_pkg::wb_link: wb_data = link;
            default:            wb_data = alu_result;
        endcase
    end

    // Data port; address is byte address bits 31:2
    assign mem_wen_D   = dec_bus.mem_write;
    assign mem_addr_D  = alu_result[riscv_pkg::pc_w+1:2];
    assign mem_wdata_D = riscv_pkg::swap64(rdata2);

endmodule

// ==== riscv_pkg.sv ====
// RV64 subset only (JAL, JALR, BEQ, BNE, LD, SD, ADDI, R-type ALU); memories hold big-endian words
package riscv_pkg;

    // Data path, register index and word PC widths
    parameter int xlen      = 64;
    parameter int reg_idx_w = 5;
    parameter int pc_w      = 30;

    // Major opcodes of the supported instructions
    typedef enum logic [6:0] {
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    // Bit 3 marks the subtract and arithmetic-shift variants,
    // the low bits follow funct3
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sub = 4'b1000,
        alu_sll = 4'b0001,
        alu_slt = 4'b0010,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_sra = 4'b1101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111
    } alu_op_e;

    // Write-back source
    typedef enum logic [1:0] {
        wb_alu  = 2'b00,
        wb_mem  = 2'b01,
        wb_link = 2'b10
    } wb_sel_e;

    // Byte reversal of a fetched instruction word
    function automatic logic [31:0] swap32(input logic [31:0] w);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = w[8*(3-i) +: 8];
        end
        return r;
    endfunction

    // Byte reversal of a data double-word, used both ways
    function automatic logic [63:0] swap64(input logic [63:0] d);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = d[8*(7-i) +: 8];
        end
        return r;
    endfunction

endpackage

// ==== tb_model.svh ====
// Reference model of the kept RV64 subset; both memory images hold 256 entries and wrap there
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef struct packed {
    logic [29:0] pc;
    logic        wen;
    logic [29:0] addr;
    logic [63:0] wdata;
} step_t;

// Program in standard form, before the big-endian swap
logic [31:0] prog [256];
int          prog_len;
logic [63:0] m_regs [32];
logic [63:0] m_mem [256];
logic [29:0] m_pc;

function automatic logic [63:0] reverse_bytes(input logic [63:0] v);
    return {v[7:0], v[15:8], v[23:16], v[31:24], v[39:32], v[47:40], v[55:48], v[63:56]};
endfunction

function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                      input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3, input int rd,
                                      input int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1, input int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1, input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

task automatic emit(input logic [31:0] w);
    prog[prog_len[7:0]] = w;
    imem[prog_len[7:0]] = riscv_pkg::swap32(w);
    prog_len++;
endtask

// Executes one instruction on the model state
function automatic step_t ref_step(input logic [31:0] ins);
    step_t       s;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [63:0] ea;
    logic [63:0] res;
    logic        wr;
    logic [29:0] npc;
    logic [2:0]  f3;
    a   = m_regs[ins[19:15]];
    b   = m_regs[ins[24:20]];
    f3  = ins[14:12];
    imm = {{52{ins[31]}}, ins[31:20]};
    ea  = a + imm;
    res = '0;
    wr  = 1'b0;
    npc = m_pc + 30'd1;
    s   = '0;
    s.pc = m_pc;
    case (ins[6:0])
        7'b1101111: begin
            imm = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            res = {32'b0, npc, 2'b00};
            wr  = 1'b1;
            npc = m_pc + imm[31:2];
        end
        7'b1100111: begin
            if (f3 == 3'd0) begin
                res = {32'b0, npc, 2'b00};
                wr  = 1'b1;
                npc = ea[31:2];
            end
        end
        7'b1100011: begin
            imm = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                npc = m_pc + imm[31:2];
            end
        end
        7'b0000011: begin
            res = m_mem[ea[10:3]];
            wr  = (f3 == 3'd3);
        end
        7'b0100011: begin
            ea = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
            if (f3 == 3'd3) begin
                s.wen   = 1'b1;
                s.addr  = ea[31:2];
                s.wdata = reverse_bytes(b);
                m_mem[ea[10:3]] = b;
            end
        end
        7'b0010011: begin
            res = ea;
            wr  = (f3 == 3'd0);
        end
        7'b0110011: begin
            wr = 1'b1;
            case ({ins[31:25], f3})
                10'b0000000_000: res = a + b;
                10'b0100000_000: res = a - b;
                10'b0000000_001: res = a << b[5:0];
                10'b0000000_010: res = {63'b0, $signed(a) < $signed(b)};
                10'b0000000_100: res = a ^ b;
                10'b0000000_101: res = a >> b[5:0];
                10'b0100000_101: res = $signed(a) >>> b[5:0];
                10'b0000000_110: res = a | b;
                10'b0000000_111: res = a & b;
                default:         wr  = 1'b0;
            endcase
        end
        default: begin
            wr = 1'b0;
        end
    endcase
    if (wr && ins[11:7] != 5'd0) begin
        m_regs[ins[11:7]] = res;
    end
    m_pc = npc;
    return s;
endfunction

task automatic build_programs();
    int f3_list [9] = '{0, 0, 1, 2, 4, 5, 5, 6, 7};
    int f7_list [9] = '{0, 32, 0, 0, 0, 0, 32, 0, 0};
    int base;
    prog_len = 0;
    // Random operands, every result goes out through SD
    emit(enc_i(0, 0, 3, 1, 7'b0000011));
    emit(enc_i(8, 0, 3, 2, 7'b0000011));
    emit(enc_s(128, 1, 0, 3));
    emit(enc_i(-1000, 1, 0, 3, 7'b0010011));
    emit(enc_s(136, 3, 0, 3));
    for (int k = 0; k < 9; k++) begin
        emit(enc_r(f7_list[k], 2, 1, f3_list[k], 4));
        emit(enc_s(144 + 8 * k, 4, 0, 3));
    end
    // Loop of three, BEQ exits and BNE goes back
    emit(enc_i(3, 0, 0, 6, 7'b0010011));
    emit(enc_i(0, 0, 0, 7, 7'b0010011));
    emit(enc_i(1, 7, 0, 7, 7'b0010011));
    emit(enc_i(-1, 6, 0, 6, 7'b0010011));
    emit(enc_b(8, 0, 6, 0));
    emit(enc_b(-12, 0, 6, 1));
    emit(enc_b(8, 0, 0, 1));
    emit(enc_s(224, 7, 0, 3));
    // JAL and JALR each skip one word
    base = prog_len;
    emit(enc_j(8, 8));
    emit(enc_i(1, 0, 0, 9, 7'b0010011));
    emit(enc_s(232, 8, 0, 3));
    emit(enc_i((base + 6) * 4 - 4, 0, 0, 10, 7'b0010011));
    emit(enc_i(4, 10, 0, 11, 7'b1100111));
    emit(enc_i(2, 0, 0, 9, 7'b0010011));
    emit(enc_s(240, 11, 0, 3));
    emit(enc_s(248, 9, 0, 3));
    // x0 writes, then illegal words that must leave x12 and memory alone
    emit(enc_i(55, 0, 0, 0, 7'b0010011));
    emit(enc_r(0, 2, 1, 0, 0));
    emit(enc_s(256, 0, 0, 3));
    emit(32'h0000_0000);
    emit(enc_r(32, 2, 1, 1, 12));
    emit(enc_i(5, 1, 2, 12, 7'b0010011));
    emit(enc_s(264, 1, 0, 2));
    emit(enc_s(272, 12, 0, 3));
    // Halt on a jump to itself
    emit(enc_j(0, 0));
endtask

`endif

// ==== tb_riscv.sv ====
// Runs with reset_pc zero and stops at the first error; programs must fit in 256 words
`timescale 1ns/1ps

module tb_riscv;

    localparam logic [29:0] reset_pc = '0;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [29:0] mem_addr_I;
    logic [31:0] mem_rdata_I;
    logic        mem_wen_D;
    logic [29:0] mem_addr_D;
    logic [63:0] mem_wdata_D;
    logic [63:0] mem_rdata_D;

    // Big-endian images as the DUT sees them
    logic [31:0] imem [256];
    logic [63:0] dmem [256];

    integer      seed;
    int          cycles = 0;
    int          cycle_limit;
    int          rst_edges = 0;
    logic [29:0] halt_pc;

    `include "tb_model.svh"

    step_t exp_s;

    riscv_core #(
        .reset_pc (reset_pc)
    ) dut_i (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    // Byte address bits 31:2 shifted once more give the double-word index
    assign mem_rdata_D = dmem[mem_addr_D[8:1]];

    always @(posedge clk) begin
        if (mem_wen_D) begin
            dmem[mem_addr_D[8:1]] <= mem_wdata_D;
        end
    end

    task automatic init_data();
        for (int i = 0; i < 256; i++) begin
            m_mem[i[7:0]] = {$random(seed), $random(seed)};
            dmem[i[7:0]]  = reverse_bytes(m_mem[i[7:0]]);
        end
        for (int r = 0; r < 32; r++) begin
            m_regs[r[4:0]] = '0;
        end
    endtask

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expv,
                                   input logic [63:0] gotv);
        stop_on_error($sformatf("Mismatch at %0t: %s expected %h, got %h",
                                $time, name, expv, gotv));
    endtask

    initial begin
        seed        = 32'h7894;
        rst_n       = 1'b0;
        mem_rdata_I = '0;
        m_pc        = reset_pc;
        init_data();
        build_programs();
        halt_pc     = 30'(prog_len - 1);
        cycle_limit = 2 * prog_len + 100;
        // Zero word during reset keeps mem_wen_D low
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        forever begin
            mem_rdata_I = imem[mem_addr_I[7:0]];
            @(negedge clk);
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            if (rst_edges > 0) begin
                assert (mem_addr_I == reset_pc)
                    else report_mismatch("mem_addr_I", 64'(reset_pc), 64'(mem_addr_I));
                assert (mem_wen_D == 1'b0)
                    else report_mismatch("mem_wen_D", 64'(0), 64'(mem_wen_D));
            end
            rst_edges = rst_edges + 1;
        end else begin
            cycles = cycles + 1;
            if (cycles > cycle_limit) begin
                stop_on_error($sformatf("Timeout: no halt within %0d cycles", cycle_limit));
            end else begin
                exp_s = ref_step(prog[m_pc[7:0]]);
                assert (mem_addr_I == exp_s.pc)
                    else report_mismatch("mem_addr_I", 64'(exp_s.pc), 64'(mem_addr_I));
                assert (mem_wen_D == exp_s.wen)
                    else report_mismatch("mem_wen_D", 64'(exp_s.wen), 64'(mem_wen_D));
                if (exp_s.wen) begin
                    assert (mem_addr_D == exp_s.addr)
                        else report_mismatch("mem_addr_D", 64'(exp_s.addr), 64'(mem_addr_D));
                    assert (mem_wdata_D == exp_s.wdata)
                        else report_mismatch("mem_wdata_D", exp_s.wdata, mem_wdata_D);
                end
                // Self-jump at the end of the programs
                if (exp_s.pc == halt_pc) begin
                    $display("TB PASSED");
                    $finish;
                end
            end
        end
    end

endmodule
